// File: Bender.yml
package:
  name: router_output_port

sources:
  - include_dirs:
      - source
    files:
      - source/arbPkg.sv
      - source/flitPkg.sv
      - source/flitFifo.sv
      - source/packetTimer.sv
      - source/portArbiter.sv
      - source/flitSwitch.sv
      - source/outputPort.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tbOutputPort.sv

// File: list.f
+incdir+source
source/arbPkg.sv
source/flitPkg.sv
source/flitFifo.sv
source/packetTimer.sv
source/portArbiter.sv
source/flitSwitch.sv
source/outputPort.sv
testbench/tbOutputPort.sv

// File: source/arbPkg.sv
`include "router_defines.svh"

package arbPkg;

  // Input sides in rotation order
  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portId_t;

  // Bit 0 is idle, bit i+1 means input i holds the output
  typedef logic [`NUM_PORTS:0] grantState_t;

  typedef logic [`NUM_PORTS-1:0] portMask_t;

  localparam grantState_t GRANT_IDLE = grantState_t'(1);

endpackage

// File: source/flitFifo.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module flitFifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  output logic              inReady,
  input  flitPkg::inFlit_t  inFlit,
  output logic              headValid,
  output flitPkg::inFlit_t  headFlit,
  input  logic              pop
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flitPkg::inFlit_t mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic push;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady = (count != CNT_W'(DEPTH));
  assign push = inValid && inReady;
  assign headValid = (count != '0);
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      // Simultaneous push and pop leaves the count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // The switch must only pop a head that is there
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> headValid);

  countInRange: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH));

endmodule

// File: source/flitPkg.sv
`include "router_defines.svh"

package flitPkg;

  typedef enum logic [`FLIT_ID_W-1:0] {
    HEAD = 3'd1,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitKind_t;

  // Length only carries meaning on a HEAD flit
  typedef struct packed {
    flitKind_t              kind;
    logic [`LENGTH_W-1:0]   length;
    logic [`PAYLOAD_W-1:0]  payload;
  } inFlit_t;

  // Output flit tagged with the input it came from
  typedef struct packed {
    arbPkg::portId_t src;
    inFlit_t         flit;
  } outFlit_t;

endpackage

// File: source/flitSwitch.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module flitSwitch (
  input  arbPkg::grantState_t grant,
  input  arbPkg::portMask_t   headValid,
  input  flitPkg::inFlit_t    headFlit [`NUM_PORTS],
  output logic                outValid,
  input  logic                outReady,
  output flitPkg::outFlit_t   outFlit,
  output arbPkg::portMask_t   pop
);

  logic accepted;

  // Select the granted head and tag it with its source port
  always_comb
  begin
    outValid = 1'b0;
    outFlit = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i + 1])
      begin
        outValid = headValid[i];
        outFlit.src = arbPkg::portId_t'(i);
        outFlit.flit = headFlit[i];
      end
    end
  end

  assign accepted = outValid && outReady;

  // Idle grant has no port bits, so nothing pops
  assign pop = accepted ? grant[`NUM_PORTS:1] : '0;

  // Relies on the arbiter keeping its grant one-hot
  popAtMostOne: assert #0 ($onehot0(pop));

endmodule

// File: source/outputPort.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module outputPort (
  input  logic              clk,
  input  logic              rst,
  input  arbPkg::portMask_t inValid,
  output arbPkg::portMask_t inReady,
  input  flitPkg::inFlit_t  inFlit [`NUM_PORTS],
  output logic              outValid,
  input  logic              outReady,
  output flitPkg::outFlit_t outFlit
);

  arbPkg::portMask_t headValid;
  arbPkg::portMask_t pop;
  flitPkg::inFlit_t headFlit [`NUM_PORTS];
  arbPkg::grantState_t grant;

  // One queue per input side
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genFifo
    flitFifo #(
      .DEPTH (`FIFO_DEPTH)
    ) fifo_i (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[i]),
      .inReady   (inReady[i]),
      .inFlit    (inFlit[i]),
      .headValid (headValid[i]),
      .headFlit  (headFlit[i]),
      .pop       (pop[i])
    );
  end

  // A non-empty queue is a request
  portArbiter arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .req       (headValid),
    .headValid (headValid),
    .headFlit  (headFlit),
    .grant     (grant)
  );

  flitSwitch switch_i (
    .grant     (grant),
    .headValid (headValid),
    .headFlit  (headFlit),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .pop       (pop)
  );

endmodule

// File: source/packetTimer.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module packetTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              headValid,
  input  flitPkg::inFlit_t  headFlit,
  input  logic              run,
  output logic              timesUp
);

  logic [`LENGTH_W-1:0] budget;
  logic [`LENGTH_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      // A new packet at the head sets the tenure budget
      if (headValid && headFlit.kind == flitPkg::HEAD)
        budget <= headFlit.length;
      if (!run)
        count <= '0;
      else
        count <= count + 1'b1;
    end
  end

  // Tenure lasts budget plus one cycles before this rises
  assign timesUp = (count == budget);

endmodule

// File: source/portArbiter.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module portArbiter (
  input  logic                clk,
  input  logic                rst,
  input  arbPkg::portMask_t   req,
  input  arbPkg::portMask_t   headValid,
  input  flitPkg::inFlit_t    headFlit [`NUM_PORTS],
  output arbPkg::grantState_t grant
);

  arbPkg::grantState_t state;
  arbPkg::grantState_t nextState;
  arbPkg::portMask_t run;
  arbPkg::portMask_t timesUp;
  logic held;
  logic picked;
  int holdIdx;
  int firstIdx;
  int cand;

  // ****************************************
  // Per-input tenure timers
  // ****************************************

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genTimer
    packetTimer timer_i (
      .clk       (clk),
      .rst       (rst),
      .headValid (headValid[i]),
      .headFlit  (headFlit[i]),
      .run       (run[i]),
      .timesUp   (timesUp[i])
    );
  end

  // ****************************************
  // Grant state machine
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbPkg::GRANT_IDLE;
    else
      state <= nextState;
  end

  assign held = !state[0];
  assign grant = state;

  always_comb
  begin
    holdIdx = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (state[i + 1])
        holdIdx = i;
    end
  end

  always_comb
  begin
    run = '0;
    nextState = arbPkg::GRANT_IDLE;
    picked = 1'b0;
    firstIdx = 0;
    cand = 0;
    if (held)
    begin
      // Search resumes at the port after the holder
      firstIdx = (holdIdx == `NUM_PORTS - 1) ? 0 : holdIdx + 1;
      if (req[holdIdx] && !timesUp[holdIdx])
      begin
        run[holdIdx] = 1'b1;
        nextState = state;
        picked = 1'b1;
      end
    end
    // The holder itself comes last in the rotation and is skipped
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      cand = firstIdx + k;
      if (cand >= `NUM_PORTS)
        cand = cand - `NUM_PORTS;
      if (!picked && req[cand] && !(held && cand == holdIdx))
      begin
        nextState = arbPkg::grantState_t'(1) << (cand + 1);
        picked = 1'b1;
      end
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

endmodule

// File: source/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// ****************************************
// Router geometry and flit field widths
// ****************************************

`define NUM_PORTS 5
`define FLIT_ID_W 3
`define LENGTH_W 12
`define PAYLOAD_W 16
`define FIFO_DEPTH 4

`endif

// File: testbench/stimulus_input.txt
# Columns: phase port kind length payload (phase and port decimal, the rest hex)
# Kinds are 1 HEAD, 2 BODY, 3 TAIL; records are grouped by port in arrival order
1 1 1 003 a100
1 1 2 000 a101
1 1 2 000 a102
1 1 3 000 a103
2 0 1 002 1000
2 0 2 000 1001
2 0 2 000 1002
2 0 3 000 1003
2 0 1 002 1010
2 0 3 000 1011
2 1 1 003 2000
2 1 2 000 2001
2 1 2 000 2002
2 1 3 000 2003
2 2 1 001 3000
2 2 2 000 3001
2 2 2 000 3002
2 2 3 000 3003
2 3 1 004 4000
2 3 2 000 4001
2 3 2 000 4002
2 3 2 000 4003
2 3 3 000 4004
2 4 1 002 5000
2 4 3 000 5001
2 4 1 002 5010
2 4 2 000 5011
2 4 3 000 5012

// File: testbench/tbOutputPort.sv
`timescale 1ns/1ps
`include "router_defines.svh"

module tbOutputPort;

  logic clk;
  logic rst;
  arbPkg::portMask_t inValid;
  arbPkg::portMask_t inReady;
  flitPkg::inFlit_t inFlit [`NUM_PORTS];
  logic outValid;
  logic outReady;
  flitPkg::outFlit_t outFlit;

  int seed = 75467;
  int errors = 0;
  bit timedOut = 0;
  int phase = 0;
  int mode = 0;
  int nRec = 0;
  flitPkg::inFlit_t stimFlit [64];
  int stimPort [64];
  int stimPhase [64];
  int pushIdx [`NUM_PORTS];
  int popIdx [`NUM_PORTS];
  int pushedCnt [`NUM_PORTS];
  int poppedCnt [`NUM_PORTS];
  int pktLen [`NUM_PORTS];
  bit waited [`NUM_PORTS];
  bit allReady = 0;
  int lastSrc = -1;
  int runLen = 0;
  int runLimit = 0;

  outputPort dut_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkOutFlit(string name, flitPkg::outFlit_t exp, flitPkg::outFlit_t act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkPort(string name, arbPkg::portId_t exp, arbPkg::portId_t act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %s actual %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic checkMask(string name, arbPkg::portMask_t exp, arbPkg::portMask_t act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Next record of port p at or after from, if its phase has started
  function automatic int findRec(int p, int from, int maxPhase);
    for (int i = from; i < nRec; i++)
    begin
      if (stimPort[i] == p)
        return (stimPhase[i] <= maxPhase) ? i : -1;
    end
    return -1;
  endfunction

  function automatic int rotDist(int from, int to);
    return (to - from + `NUM_PORTS) % `NUM_PORTS;
  endfunction

  task automatic loadStimulus();
    int fd;
    int ph;
    int port;
    int kind;
    int len;
    int payload;
    string line;
    fd = $fopen("testbench/stimulus_input.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the stimulus file");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 2 && line.getc(0) != "#")
      begin
        void'($sscanf(line, "%d %d %h %h %h", ph, port, kind, len, payload));
        stimPhase[nRec] = ph;
        stimPort[nRec] = port;
        stimFlit[nRec].kind = flitPkg::flitKind_t'(kind);
        stimFlit[nRec].length = len;
        stimFlit[nRec].payload = payload;
        nRec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive();
    int idx;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      idx = findRec(p, pushIdx[p], phase);
      inValid[p] = (idx >= 0);
      if (idx >= 0)
      begin
        pushIdx[p] = idx;
        inFlit[p] = stimFlit[idx];
      end
    end
    if (mode == 0)
      outReady = 1'b1;
    else if (mode == 1)
      outReady = 1'b0;
    else
      outReady = (($random(seed) & 3) != 0);
  endtask

  // Scoreboard, rotation and tenure checks on the settled cycle
  task automatic evaluate();
    arbPkg::portMask_t expReady;
    flitPkg::outFlit_t exp;
    int occ [`NUM_PORTS];
    int src;
    int idx;
    int fairQ;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      occ[p] = pushedCnt[p] - poppedCnt[p];
      expReady[p] = (occ[p] < `FIFO_DEPTH);
      waited[p] = waited[p] && (occ[p] > 0);
    end
    allReady = allReady && outReady;
    checkMask("inReady", expReady, inReady);
    // A grant shown for another port restarts the tenure even without a transfer
    if (!outValid || int'(outFlit.src) != lastSrc)
      runLen = 0;
    if (outValid && outReady)
    begin
      src = int'(outFlit.src);
      idx = findRec(src, popIdx[src], 9);
      if (poppedCnt[src] >= pushedCnt[src] || idx < 0)
      begin
        errors++;
        $display("flit from port %0d left with nothing queued at %0t", src, $time);
      end
      else
      begin
        exp.src = arbPkg::portId_t'(src);
        exp.flit = stimFlit[idx];
        checkOutFlit("outFlit", exp, outFlit);
        popIdx[src] = idx + 1;
        poppedCnt[src]++;
      end
      if (phase == 1)
        checkPort("outFlit.src", arbPkg::PORT_N, outFlit.src);
      fairQ = -1;
      for (int k = 1; k < `NUM_PORTS && lastSrc >= 0; k++)
      begin
        if (fairQ < 0 && waited[(lastSrc + k) % `NUM_PORTS])
          fairQ = (lastSrc + k) % `NUM_PORTS;
      end
      if (src != lastSrc && lastSrc >= 0 && allReady && fairQ >= 0)
      begin
        if (rotDist(lastSrc, src) > rotDist(lastSrc, fairQ))
          checkPort("outFlit.src", arbPkg::portId_t'(fairQ), outFlit.src);
      end
      runLen++;
      if (outFlit.flit.kind == flitPkg::HEAD)
        pktLen[src] = outFlit.flit.length;
      if (runLen == 1 || pktLen[src] > runLimit)
        runLimit = pktLen[src];
      if (runLen > runLimit + 1)
      begin
        errors++;
        $display("port %0d held the output for %0d flits at %0t", src, runLen, $time);
      end
      lastSrc = src;
      allReady = outReady;
      for (int p = 0; p < `NUM_PORTS; p++)
        waited[p] = (occ[p] > 0);
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (inValid[p] && inReady[p])
      begin
        pushedCnt[p]++;
        pushIdx[p]++;
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    drive();
    #1;
    evaluate();
  endtask

  function automatic bit allDelivered();
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (findRec(p, pushIdx[p], phase) >= 0 || poppedCnt[p] != pushedCnt[p])
        return 0;
    end
    return 1;
  endfunction

  task automatic drainTraffic(int limit);
    int cycles;
    cycles = 0;
    while (!allDelivered() && !timedOut)
    begin
      step();
      cycles++;
      if (cycles > limit)
      begin
        timedOut = 1;
        errors++;
        $display("timed out waiting for phase %0d traffic to drain", phase);
      end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlit[p] = '0;
      pushIdx[p] = 0;
      popIdx[p] = 0;
      pushedCnt[p] = 0;
      poppedCnt[p] = 0;
      pktLen[p] = 0;
      waited[p] = 0;
    end
    loadStimulus();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    checkBit("outValid", 1'b0, outValid);
    checkMask("inReady", '1, inReady);

    // ****************************************
    // Single packet on N, then full load with back-pressure
    // ****************************************
    phase = 1;
    mode = 0;
    drainTraffic(200);
    if (!timedOut)
    begin
      phase = 2;
      mode = 1;
      repeat (40) step();
      mode = 2;
      drainTraffic(2000);
    end
    $display("errors: %0d", errors);
    if (errors == 0 && !timedOut)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule
